// File: Makefile
TOP := tb_axi_jesd_rx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: axi_jesd_rx_regs.sv
// Top level of the JESD204 RX register interface; joins the AXI bridge and register blocks
`timescale 1ns/1ps
`default_nettype none
`include "jesd_rx_consts.svh"

module axi_jesd_rx_regs import jesd_rx_pkg::*; (
  input  logic                       s_axi_aclk,
  input  logic                       rst_n,
  input  logic                       s_axi_awvalid,
  input  logic [`JRX_AXI_ADDR_W-1:0] s_axi_awaddr,
  output logic                       s_axi_awready,
  input  logic                       s_axi_wvalid,
  input  logic [31:0]                s_axi_wdata,
  input  logic [3:0]                 s_axi_wstrb,
  output logic                       s_axi_wready,
  output logic                       s_axi_bvalid,
  output logic [1:0]                 s_axi_bresp,
  input  logic                       s_axi_bready,
  input  logic                       s_axi_arvalid,
  input  logic [`JRX_AXI_ADDR_W-1:0] s_axi_araddr,
  output logic                       s_axi_arready,
  output logic                       s_axi_rvalid,
  input  logic                       s_axi_rready,
  output logic [1:0]                 s_axi_rresp,
  output logic [31:0]                s_axi_rdata,
  output logic                       irq,
  output core_cfg_t                  core_cfg,
  output device_cfg_t                device_cfg,
  output logic [6:0]                 err_stats_mask,
  output logic                       err_stats_reset,
  input  rx_status_t                 rx_status,
  input  logic                       event_frame_align_err,
  input  logic                       event_lane_state_err,
  input  logic                       event_sysref_edge,
  input  logic                       event_sysref_align_err
);

  up_bus_t          up_bus;
  logic             wack;
  logic             rack;
  logic             rreq_d1;
  logic [31:0]      rdata;
  logic [31:0]      rdata_common;
  logic [31:0]      rdata_sysref;
  logic [31:0]      rdata_rx;
  logic             cfg_writeable;
  core_link_cfg_t   core_link_cfg;
  device_link_cfg_t device_link_cfg;
  sysref_cfg_t      sysref_cfg;
  buffer_cfg_t      buffer_cfg;
  logic [7:0]       frame_align_err_threshold;

  ////////////////////////////////////////////////////////////
  // Acknowledge timing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wack    <= 1'b0;
      rreq_d1 <= 1'b0;
      rack    <= 1'b0;
    end else begin
      wack    <= up_bus.wreq;
      rreq_d1 <= up_bus.rreq;
      rack    <= rreq_d1;  // Two cycles after rreq
    end
  end

  // Blocks drive zero outside their own addresses
  always_ff @(posedge s_axi_aclk) begin
    if (rreq_d1) rdata <= rdata_common | rdata_sysref | rdata_rx;
  end

  up_axi_bridge i_bridge (
    .s_axi_aclk, .rst_n,
    .s_axi_awvalid, .s_axi_awaddr, .s_axi_awready,
    .s_axi_wvalid, .s_axi_wdata, .s_axi_wstrb, .s_axi_wready,
    .s_axi_bvalid, .s_axi_bresp, .s_axi_bready,
    .s_axi_arvalid, .s_axi_araddr, .s_axi_arready,
    .s_axi_rvalid, .s_axi_rresp, .s_axi_rdata, .s_axi_rready,
    .up_bus, .wack, .rack, .rdata
  );

  jesd_up_common i_common (
    .s_axi_aclk, .rst_n, .up_bus,
    .event_frame_align_err, .event_lane_state_err,
    .rdata               (rdata_common),
    .cfg_writeable,
    .core_cfg            (core_link_cfg),
    .link_cfg_for_device (device_link_cfg),
    .irq
  );

  jesd_up_sysref i_sysref (
    .s_axi_aclk, .rst_n, .up_bus, .cfg_writeable,
    .event_sysref_edge, .event_sysref_align_err,
    .rdata      (rdata_sysref),
    .sysref_cfg
  );

  jesd_up_rx i_rx (
    .s_axi_aclk, .rst_n, .up_bus, .cfg_writeable, .rx_status,
    .rdata (rdata_rx),
    .buffer_cfg, .frame_align_err_threshold,
    .err_stats_mask, .err_stats_reset
  );

  ////////////////////////////////////////////////////////////
  // Configuration assembly
  ////////////////////////////////////////////////////////////
  assign core_cfg = '{
    lanes_disable:             core_link_cfg.lanes_disable,
    octets_per_frame:          core_link_cfg.octets_per_frame,
    octets_per_multiframe:     core_link_cfg.octets_per_multiframe,
    disable_scrambler:         core_link_cfg.disable_scrambler,
    disable_char_replacement:  core_link_cfg.disable_char_replacement,
    frame_align_err_threshold: frame_align_err_threshold
  };

  assign device_cfg = '{
    octets_per_multiframe: device_link_cfg.octets_per_multiframe,
    octets_per_frame:      device_link_cfg.octets_per_frame,
    beats_per_multiframe:  device_link_cfg.beats_per_multiframe,
    lmfc_offset:           sysref_cfg.lmfc_offset,
    sysref_oneshot:        sysref_cfg.sysref_oneshot,
    sysref_disable:        sysref_cfg.sysref_disable,
    buffer_early_release:  buffer_cfg.buffer_early_release,
    buffer_delay:          buffer_cfg.buffer_delay
  };

endmodule

`default_nettype wire

// File: jesd_rx_consts.svh
// Shared constants of the JESD204 RX register map; include in RTL and testbench
`ifndef JESD_RX_CONSTS_SVH
`define JESD_RX_CONSTS_SVH

`define JRX_NUM_LANES   4
`define JRX_AXI_ADDR_W  14             // Byte address on the bus
`define JRX_UP_ADDR_W   12             // Word address on the register strobes

`define JRX_VERSION     32'h00010161
`define JRX_MAGIC       32'h32303452   // "204R"

////////////////////////////////////////////////////////////
// Register word addresses
////////////////////////////////////////////////////////////
`define JRX_REG_VERSION               12'h000
`define JRX_REG_SCRATCH               12'h002
`define JRX_REG_MAGIC                 12'h003
`define JRX_REG_IRQ_ENABLE            12'h004
`define JRX_REG_IRQ_PENDING           12'h005
`define JRX_REG_LINK_DISABLE          12'h010
`define JRX_REG_LANES_DISABLE         12'h020
`define JRX_REG_OCTETS_PER_FRAME      12'h021
`define JRX_REG_OCTETS_PER_MULTIFRAME 12'h022
`define JRX_REG_LINK_FLAGS            12'h023
`define JRX_REG_SYSREF_CONF           12'h040
`define JRX_REG_LMFC_OFFSET           12'h041
`define JRX_REG_SYSREF_STATUS         12'h042
`define JRX_REG_BUFFER_CONF           12'h090
`define JRX_REG_ALIGN_ERR_THRESHOLD   12'h091
`define JRX_REG_ERR_STATS_CTRL        12'h092
`define JRX_REG_CTRL_STATE            12'h0A0
`define JRX_REG_LANE0_STATUS          12'h0C0   // One word per lane upwards

`endif

// File: jesd_rx_pkg.sv
// Struct types passed between the AXI bridge, the register blocks and the top level
`default_nettype none
`include "jesd_rx_consts.svh"

package jesd_rx_pkg;

  typedef struct packed {
    logic                      wreq;
    logic [`JRX_UP_ADDR_W-1:0] waddr;
    logic [31:0]               wdata;
    logic                      rreq;
    logic [`JRX_UP_ADDR_W-1:0] raddr;
  } up_bus_t;

  typedef struct packed {
    logic [`JRX_NUM_LANES-1:0] lanes_disable;
    logic [7:0]                octets_per_frame;
    logic [9:0]                octets_per_multiframe;
    logic                      disable_scrambler;
    logic                      disable_char_replacement;
    logic [7:0]                frame_align_err_threshold;
  } core_cfg_t;

  typedef struct packed {
    logic [9:0] octets_per_multiframe;
    logic [7:0] octets_per_frame;
    logic [7:0] beats_per_multiframe;
    logic [7:0] lmfc_offset;
    logic       sysref_oneshot;
    logic       sysref_disable;
    logic       buffer_early_release;
    logic [7:0] buffer_delay;
  } device_cfg_t;

  // Slices of the two configuration structs, one per register block
  typedef struct packed {
    logic [`JRX_NUM_LANES-1:0] lanes_disable;
    logic [7:0]                octets_per_frame;
    logic [9:0]                octets_per_multiframe;
    logic                      disable_scrambler;
    logic                      disable_char_replacement;
  } core_link_cfg_t;

  typedef struct packed {
    logic [9:0] octets_per_multiframe;
    logic [7:0] octets_per_frame;
    logic [7:0] beats_per_multiframe;
  } device_link_cfg_t;

  typedef struct packed {
    logic [7:0] lmfc_offset;
    logic       sysref_oneshot;
    logic       sysref_disable;
  } sysref_cfg_t;

  typedef struct packed {
    logic [7:0] buffer_delay;
    logic       buffer_early_release;
  } buffer_cfg_t;

  typedef struct packed {
    logic [1:0] cgs_state;
    logic [2:0] emb_state;
    logic       ifs_ready;
  } lane_status_t;

  typedef struct packed {
    logic [1:0]                               ctrl_state;
    lane_status_t [`JRX_NUM_LANES-1:0]        lanes;
  } rx_status_t;

endpackage

`default_nettype wire

// File: jesd_up_common.sv
// Common register block with identification, link enable, link configuration and interrupts
`timescale 1ns/1ps
`default_nettype none
`include "jesd_rx_consts.svh"

module jesd_up_common import jesd_rx_pkg::*; (
  input  logic             s_axi_aclk,
  input  logic             rst_n,
  input  up_bus_t          up_bus,
  input  logic             event_frame_align_err,
  input  logic             event_lane_state_err,
  output logic [31:0]      rdata,
  output logic             cfg_writeable,
  output core_link_cfg_t   core_cfg,
  output device_link_cfg_t link_cfg_for_device,
  output logic             irq
);

  logic [31:0] scratch;
  logic        link_disable;
  logic [1:0]  irq_enable;
  logic [1:0]  irq_pending;
  logic [1:0]  irq_trigger;
  logic [1:0]  irq_clear;
  logic        wr_cfg;

  assign cfg_writeable = link_disable;
  assign wr_cfg        = up_bus.wreq && cfg_writeable;

  // Events only count while the link runs
  assign irq_trigger = {event_lane_state_err, event_frame_align_err} & {2{~cfg_writeable}};
  assign irq_clear   = (up_bus.wreq && up_bus.waddr == `JRX_REG_IRQ_PENDING) ?
                       up_bus.wdata[1:0] : 2'b00;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      scratch      <= '0;
      link_disable <= 1'b1;
      irq_enable   <= '0;
      irq_pending  <= '0;
      irq          <= 1'b0;
      core_cfg     <= '0;
    end else begin
      irq_pending <= (irq_pending & ~irq_clear) | irq_trigger;  // Set wins over clear
      irq         <= |(irq_pending & irq_enable);
      if (up_bus.wreq) begin
        case (up_bus.waddr)
          `JRX_REG_SCRATCH:      scratch      <= up_bus.wdata;
          `JRX_REG_IRQ_ENABLE:   irq_enable   <= up_bus.wdata[1:0];
          `JRX_REG_LINK_DISABLE: link_disable <= up_bus.wdata[0];
          default: ;
        endcase
      end
      if (wr_cfg) begin
        case (up_bus.waddr)
          `JRX_REG_LANES_DISABLE:
            core_cfg.lanes_disable <= up_bus.wdata[`JRX_NUM_LANES-1:0];
          `JRX_REG_OCTETS_PER_FRAME:      core_cfg.octets_per_frame <= up_bus.wdata[7:0];
          `JRX_REG_OCTETS_PER_MULTIFRAME: core_cfg.octets_per_multiframe <= up_bus.wdata[9:0];
          `JRX_REG_LINK_FLAGS: begin
            core_cfg.disable_scrambler        <= up_bus.wdata[0];
            core_cfg.disable_char_replacement <= up_bus.wdata[1];
          end
          default: ;
        endcase
      end
    end
  end

  // 4-byte data path, so four octets per beat
  assign link_cfg_for_device = '{
    octets_per_multiframe: core_cfg.octets_per_multiframe,
    octets_per_frame:      core_cfg.octets_per_frame,
    beats_per_multiframe:  core_cfg.octets_per_multiframe[9:2]
  };

  always_comb begin
    case (up_bus.raddr)
      `JRX_REG_VERSION:               rdata = `JRX_VERSION;
      `JRX_REG_SCRATCH:               rdata = scratch;
      `JRX_REG_MAGIC:                 rdata = `JRX_MAGIC;
      `JRX_REG_IRQ_ENABLE:            rdata = 32'(irq_enable);
      `JRX_REG_IRQ_PENDING:           rdata = 32'(irq_pending);
      `JRX_REG_LINK_DISABLE:          rdata = 32'(link_disable);
      `JRX_REG_LANES_DISABLE:         rdata = 32'(core_cfg.lanes_disable);
      `JRX_REG_OCTETS_PER_FRAME:      rdata = 32'(core_cfg.octets_per_frame);
      `JRX_REG_OCTETS_PER_MULTIFRAME: rdata = 32'(core_cfg.octets_per_multiframe);
      `JRX_REG_LINK_FLAGS:
        rdata = {30'b0, core_cfg.disable_char_replacement, core_cfg.disable_scrambler};
      default:                        rdata = '0;
    endcase
  end

  a_no_irq_when_disabled: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    cfg_writeable |=> ((irq_pending & ~$past(irq_pending)) == 2'b00));

endmodule

`default_nettype wire

// File: jesd_up_rx.sv
// RX register block with buffer configuration, error statistics control and lane status
`timescale 1ns/1ps
`default_nettype none
`include "jesd_rx_consts.svh"

module jesd_up_rx import jesd_rx_pkg::*; (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  up_bus_t     up_bus,
  input  logic        cfg_writeable,
  input  rx_status_t  rx_status,
  output logic [31:0] rdata,
  output buffer_cfg_t buffer_cfg,
  output logic [7:0]  frame_align_err_threshold,
  output logic [6:0]  err_stats_mask,
  output logic        err_stats_reset
);

  logic wr_stats;

  assign wr_stats = up_bus.wreq && up_bus.waddr == `JRX_REG_ERR_STATS_CTRL;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      buffer_cfg                <= '0;
      frame_align_err_threshold <= 8'd4;
      err_stats_mask            <= '0;
      err_stats_reset           <= 1'b0;
    end else begin
      err_stats_reset <= wr_stats && up_bus.wdata[0];  // One-cycle pulse
      if (wr_stats) err_stats_mask <= up_bus.wdata[14:8];
      if (up_bus.wreq && cfg_writeable) begin
        case (up_bus.waddr)
          `JRX_REG_BUFFER_CONF: begin
            buffer_cfg.buffer_delay         <= up_bus.wdata[7:0];
            buffer_cfg.buffer_early_release <= up_bus.wdata[16];
          end
          `JRX_REG_ALIGN_ERR_THRESHOLD: frame_align_err_threshold <= up_bus.wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (up_bus.raddr)
      `JRX_REG_BUFFER_CONF:
        rdata = {15'b0, buffer_cfg.buffer_early_release, 8'b0, buffer_cfg.buffer_delay};
      `JRX_REG_ALIGN_ERR_THRESHOLD: rdata = 32'(frame_align_err_threshold);
      `JRX_REG_ERR_STATS_CTRL:      rdata = {17'b0, err_stats_mask, 8'b0};
      `JRX_REG_CTRL_STATE:          rdata = 32'(rx_status.ctrl_state);
      default: ;
    endcase
    // Lane status words
    for (int i = 0; i < `JRX_NUM_LANES; i++) begin
      if (up_bus.raddr == `JRX_UP_ADDR_W'(`JRX_REG_LANE0_STATUS + i)) begin
        rdata = {23'b0, rx_status.lanes[i].ifs_ready, 1'b0,
                 rx_status.lanes[i].emb_state, 2'b0, rx_status.lanes[i].cgs_state};
      end
    end
  end

  a_stats_reset_pulse: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    err_stats_reset |=> !err_stats_reset);

endmodule

`default_nettype wire

// File: jesd_up_sysref.sv
// SYSREF register block with protected SYSREF configuration and sticky event status
`timescale 1ns/1ps
`default_nettype none
`include "jesd_rx_consts.svh"

module jesd_up_sysref import jesd_rx_pkg::*; (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  up_bus_t     up_bus,
  input  logic        cfg_writeable,
  input  logic        event_sysref_edge,
  input  logic        event_sysref_align_err,
  output logic [31:0] rdata,
  output sysref_cfg_t sysref_cfg
);

  logic [1:0] status;
  logic [1:0] status_clear;

  assign status_clear = (up_bus.wreq && up_bus.waddr == `JRX_REG_SYSREF_STATUS) ?
                        up_bus.wdata[1:0] : 2'b00;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      status     <= '0;
      sysref_cfg <= '0;
    end else begin
      // Sticky in any link state
      status <= (status & ~status_clear) | {event_sysref_align_err, event_sysref_edge};
      if (up_bus.wreq && cfg_writeable) begin
        case (up_bus.waddr)
          `JRX_REG_SYSREF_CONF: begin
            sysref_cfg.sysref_disable <= up_bus.wdata[0];
            sysref_cfg.sysref_oneshot <= up_bus.wdata[1];
          end
          `JRX_REG_LMFC_OFFSET: sysref_cfg.lmfc_offset <= up_bus.wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (up_bus.raddr)
      `JRX_REG_SYSREF_CONF:
        rdata = {30'b0, sysref_cfg.sysref_oneshot, sysref_cfg.sysref_disable};
      `JRX_REG_LMFC_OFFSET:   rdata = 32'(sysref_cfg.lmfc_offset);
      `JRX_REG_SYSREF_STATUS: rdata = 32'(status);
      default:                rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: tb_axi_jesd_rx.sv
// Directed testbench for the JESD204 RX register interface; compile with vlog.f as the top module
`timescale 1ns/1ps
`default_nettype none
`include "jesd_rx_consts.svh"

module tb_axi_jesd_rx import jesd_rx_pkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  localparam int HS_LIMIT        = 20;   // Cycles allowed for one AXI handshake

  logic                       s_axi_aclk = 1'b0;
  logic                       rst_n;
  logic                       s_axi_awvalid;
  logic [`JRX_AXI_ADDR_W-1:0] s_axi_awaddr;
  logic                       s_axi_awready;
  logic                       s_axi_wvalid;
  logic [31:0]                s_axi_wdata;
  logic [3:0]                 s_axi_wstrb;
  logic                       s_axi_wready;
  logic                       s_axi_bvalid;
  logic [1:0]                 s_axi_bresp;
  logic                       s_axi_bready;
  logic                       s_axi_arvalid;
  logic [`JRX_AXI_ADDR_W-1:0] s_axi_araddr;
  logic                       s_axi_arready;
  logic                       s_axi_rvalid;
  logic                       s_axi_rready;
  logic [1:0]                 s_axi_rresp;
  logic [31:0]                s_axi_rdata;
  logic                       irq;
  core_cfg_t                  core_cfg;
  device_cfg_t                device_cfg;
  logic [6:0]                 err_stats_mask;
  logic                       err_stats_reset;
  rx_status_t                 rx_status;
  logic [3:0]                 events;   // Frame align, lane state, SYSREF edge, SYSREF align

  int          errors       = 0;
  int          checks       = 0;
  int          reset_pulses = 0;
  logic [31:0] seed         = 32'd54112;

  // Protected configuration registers and their field masks
  logic [11:0] cfg_addr [8] = '{`JRX_REG_LANES_DISABLE, `JRX_REG_OCTETS_PER_FRAME,
                                `JRX_REG_OCTETS_PER_MULTIFRAME, `JRX_REG_LINK_FLAGS,
                                `JRX_REG_SYSREF_CONF, `JRX_REG_LMFC_OFFSET,
                                `JRX_REG_BUFFER_CONF, `JRX_REG_ALIGN_ERR_THRESHOLD};
  logic [31:0] cfg_mask [8] = '{32'h0000_000f, 32'h0000_00ff, 32'h0000_03ff, 32'h0000_0003,
                                32'h0000_0003, 32'h0000_00ff, 32'h0001_00ff, 32'h0000_00ff};
  logic [31:0] cfg_exp  [8];

  axi_jesd_rx_regs UUT (
    .s_axi_aclk, .rst_n,
    .s_axi_awvalid, .s_axi_awaddr, .s_axi_awready,
    .s_axi_wvalid, .s_axi_wdata, .s_axi_wstrb, .s_axi_wready,
    .s_axi_bvalid, .s_axi_bresp, .s_axi_bready,
    .s_axi_arvalid, .s_axi_araddr, .s_axi_arready,
    .s_axi_rvalid, .s_axi_rready, .s_axi_rresp, .s_axi_rdata,
    .irq, .core_cfg, .device_cfg, .err_stats_mask, .err_stats_reset, .rx_status,
    .event_frame_align_err  (events[0]),
    .event_lane_state_err   (events[1]),
    .event_sysref_edge      (events[2]),
    .event_sysref_align_err (events[3])
  );

  always #(CLK_PERIOD/2) s_axi_aclk = ~s_axi_aclk;

  always @(negedge s_axi_aclk) begin
    if (err_stats_reset) reset_pulses++;  // High cycles of the statistics reset
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD + 10 * CLK_PERIOD);
    $display("Watchdog expired before the last test finished");
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge s_axi_aclk);
      #1;
    end
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
    int cycles;
    s_axi_awaddr  = {addr, 2'b00};
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    cycles        = 0;
    do begin
      @(posedge s_axi_aclk);
      #1;
      cycles++;
    end while (!(s_axi_awready && s_axi_wready) && cycles < HS_LIMIT);
    if (!(s_axi_awready && s_axi_wready)) begin
      errors++;
      $display("AXI write to word 0x%03h was never accepted", addr);
    end
    @(posedge s_axi_aclk);  // Handshake edge
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    cycles        = 1;
    while (!s_axi_bvalid && cycles < HS_LIMIT) begin
      @(posedge s_axi_aclk);
      #1;
      cycles++;
    end
    check_value("write response latency", cycles, 2);
    check_value("s_axi_bresp", 32'(s_axi_bresp), 0);
    idle_cycles(1);  // bready is held high
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    int cycles;
    s_axi_araddr  = {addr, 2'b00};
    s_axi_arvalid = 1'b1;
    cycles        = 0;
    do begin
      @(posedge s_axi_aclk);
      #1;
      cycles++;
    end while (!s_axi_arready && cycles < HS_LIMIT);
    if (!s_axi_arready) begin
      errors++;
      $display("AXI read from word 0x%03h was never accepted", addr);
    end
    @(posedge s_axi_aclk);
    #1;
    s_axi_arvalid = 1'b0;
    cycles        = 1;
    while (!s_axi_rvalid && cycles < HS_LIMIT) begin
      @(posedge s_axi_aclk);
      #1;
      cycles++;
    end
    check_value("read data latency", cycles, 3);
    check_value("s_axi_rresp", 32'(s_axi_rresp), 0);
    data = s_axi_rdata;
    idle_cycles(1);
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    axi_read(addr, data);
    check_value($sformatf("register 0x%03h", addr), data, expected);
  endtask

  task automatic pulse_event(input int idx);
    events[idx] = 1'b1;
    idle_cycles(1);
    events = '0;
  endtask

  task automatic compare_config_outputs();
    check_value("core_cfg.lanes_disable", 32'(core_cfg.lanes_disable), cfg_exp[0]);
    check_value("core_cfg.octets_per_frame", 32'(core_cfg.octets_per_frame), cfg_exp[1]);
    check_value("core_cfg.octets_per_multiframe", 32'(core_cfg.octets_per_multiframe),
                cfg_exp[2]);
    check_value("core_cfg.disable_scrambler", 32'(core_cfg.disable_scrambler),
                32'(cfg_exp[3][0]));
    check_value("core_cfg.disable_char_replacement", 32'(core_cfg.disable_char_replacement),
                32'(cfg_exp[3][1]));
    check_value("core_cfg.frame_align_err_threshold",
                32'(core_cfg.frame_align_err_threshold), cfg_exp[7]);
    check_value("device_cfg.octets_per_multiframe", 32'(device_cfg.octets_per_multiframe),
                cfg_exp[2]);
    check_value("device_cfg.octets_per_frame", 32'(device_cfg.octets_per_frame), cfg_exp[1]);
    check_value("device_cfg.beats_per_multiframe", 32'(device_cfg.beats_per_multiframe),
                cfg_exp[2] / 4);
    check_value("device_cfg.lmfc_offset", 32'(device_cfg.lmfc_offset), cfg_exp[5]);
    check_value("device_cfg.sysref_disable", 32'(device_cfg.sysref_disable),
                32'(cfg_exp[4][0]));
    check_value("device_cfg.sysref_oneshot", 32'(device_cfg.sysref_oneshot),
                32'(cfg_exp[4][1]));
    check_value("device_cfg.buffer_early_release", 32'(device_cfg.buffer_early_release),
                32'(cfg_exp[6][16]));
    check_value("device_cfg.buffer_delay", 32'(device_cfg.buffer_delay),
                32'(cfg_exp[6][7:0]));
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic reset_defaults();
    read_check(`JRX_REG_VERSION, `JRX_VERSION);
    read_check(`JRX_REG_MAGIC, `JRX_MAGIC);
    read_check(`JRX_REG_LINK_DISABLE, 32'd1);
    read_check(`JRX_REG_ALIGN_ERR_THRESHOLD, 32'd4);
    check_value("irq", 32'(irq), 0);
    check_value("err_stats_reset", 32'(err_stats_reset), 0);
    check_value("core_cfg.frame_align_err_threshold",
                32'(core_cfg.frame_align_err_threshold), 4);
  endtask

  task automatic config_readback();
    logic [31:0] raw;
    for (int i = 0; i < 8; i++) begin
      raw        = next_random();
      cfg_exp[i] = raw & cfg_mask[i];
      axi_write(cfg_addr[i], raw);
    end
    for (int i = 0; i < 8; i++) read_check(cfg_addr[i], cfg_exp[i]);
    compare_config_outputs();
  endtask

  task automatic write_protection();
    logic [31:0] data;
    axi_write(`JRX_REG_LINK_DISABLE, 32'd0);
    read_check(`JRX_REG_LINK_DISABLE, 32'd0);
    for (int i = 0; i < 8; i++) axi_write(cfg_addr[i], ~cfg_exp[i]);  // Every field differs
    for (int i = 0; i < 8; i++) read_check(cfg_addr[i], cfg_exp[i]);
    compare_config_outputs();
    data = next_random();
    axi_write(`JRX_REG_SCRATCH, data);
    read_check(`JRX_REG_SCRATCH, data);
  endtask

  task automatic interrupt_flow();
    axi_write(`JRX_REG_LINK_DISABLE, 32'd1);
    axi_write(`JRX_REG_IRQ_ENABLE, 32'd1);
    pulse_event(0);
    idle_cycles(2);
    check_value("irq", 32'(irq), 0);
    read_check(`JRX_REG_IRQ_PENDING, 32'd0);
    axi_write(`JRX_REG_LINK_DISABLE, 32'd0);
    pulse_event(0);
    idle_cycles(1);  // Pending set, irq one cycle later
    check_value("irq", 32'(irq), 1);
    read_check(`JRX_REG_IRQ_PENDING, 32'd1);
    axi_write(`JRX_REG_IRQ_PENDING, 32'd1);
    idle_cycles(1);
    check_value("irq", 32'(irq), 0);
    read_check(`JRX_REG_IRQ_PENDING, 32'd0);
    pulse_event(1);
    idle_cycles(2);
    check_value("irq", 32'(irq), 0);  // Lane state interrupt not enabled
    read_check(`JRX_REG_IRQ_PENDING, 32'd2);
    axi_write(`JRX_REG_IRQ_PENDING, 32'd2);
    read_check(`JRX_REG_IRQ_PENDING, 32'd0);
  endtask

  task automatic sysref_sticky_status();
    pulse_event(2);
    read_check(`JRX_REG_SYSREF_STATUS, 32'd1);
    pulse_event(3);
    idle_cycles(20);
    read_check(`JRX_REG_SYSREF_STATUS, 32'd3);
    axi_write(`JRX_REG_SYSREF_STATUS, 32'd1);
    read_check(`JRX_REG_SYSREF_STATUS, 32'd2);
    axi_write(`JRX_REG_SYSREF_STATUS, 32'd2);
    read_check(`JRX_REG_SYSREF_STATUS, 32'd0);
  endtask

  task automatic rx_status_readback();
    logic [31:0] r;
    logic [31:0] lane_word;
    logic [6:0]  mask;
    int          pulses_before;
    repeat (2) begin
      r         = next_random();
      rx_status = rx_status_t'(r[$bits(rx_status_t)-1:0]);
      read_check(`JRX_REG_CTRL_STATE, 32'(rx_status.ctrl_state));
      for (int i = 0; i < `JRX_NUM_LANES; i++) begin
        lane_word      = '0;
        lane_word[8]   = rx_status.lanes[i].ifs_ready;
        lane_word[6:4] = rx_status.lanes[i].emb_state;
        lane_word[1:0] = rx_status.lanes[i].cgs_state;
        read_check(12'(`JRX_REG_LANE0_STATUS + i), lane_word);
      end
    end
    r             = next_random();
    mask          = r[6:0];
    pulses_before = reset_pulses;
    axi_write(`JRX_REG_ERR_STATS_CTRL, {17'b0, mask, 8'b0} | 32'd1);
    idle_cycles(5);
    check_value("err_stats_reset high cycles", reset_pulses - pulses_before, 1);
    check_value("err_stats_mask", 32'(err_stats_mask), 32'(mask));
    check_value("err_stats_reset", 32'(err_stats_reset), 0);
    read_check(`JRX_REG_ERR_STATS_CTRL, {17'b0, mask, 8'b0});
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst_n         = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = 4'hf;
    s_axi_bready  = 1'b1;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_rready  = 1'b1;
    rx_status     = '0;
    events        = '0;
    repeat (10) @(posedge s_axi_aclk);
    #1;
    rst_n = 1'b1;
    idle_cycles(2);

    reset_defaults();
    config_readback();
    write_protection();
    interrupt_flow();
    sysref_sticky_status();
    rx_status_readback();

    $display("%0d checks done, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: up_axi_bridge.sv
// AXI4-Lite slave that turns bus transfers into one-cycle register strobes for the blocks
`timescale 1ns/1ps
`default_nettype none
`include "jesd_rx_consts.svh"

module up_axi_bridge import jesd_rx_pkg::*; (
  input  logic                       s_axi_aclk,
  input  logic                       rst_n,
  input  logic                       s_axi_awvalid,
  input  logic [`JRX_AXI_ADDR_W-1:0] s_axi_awaddr,
  output logic                       s_axi_awready,
  input  logic                       s_axi_wvalid,
  input  logic [31:0]                s_axi_wdata,
  input  logic [3:0]                 s_axi_wstrb,
  output logic                       s_axi_wready,
  output logic                       s_axi_bvalid,
  output logic [1:0]                 s_axi_bresp,
  input  logic                       s_axi_bready,
  input  logic                       s_axi_arvalid,
  input  logic [`JRX_AXI_ADDR_W-1:0] s_axi_araddr,
  output logic                       s_axi_arready,
  output logic                       s_axi_rvalid,
  output logic [1:0]                 s_axi_rresp,
  output logic [31:0]                s_axi_rdata,
  input  logic                       s_axi_rready,
  output up_bus_t                    up_bus,
  input  logic                       wack,
  input  logic                       rack,
  input  logic [31:0]                rdata
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_WAIT,
    ST_WR_RESP,
    ST_RD_WAIT,
    ST_RD_RESP
  } state_t;

  state_t                    state;
  logic                      wreq;
  logic                      rreq;
  logic [`JRX_UP_ADDR_W-1:0] waddr;
  logic [`JRX_UP_ADDR_W-1:0] raddr;
  logic [31:0]               wdata;
  logic                      wr_start;
  logic                      rd_start;

  assign wr_start = (state == ST_IDLE) && s_axi_awvalid && s_axi_wvalid;
  assign rd_start = (state == ST_IDLE) && !wr_start && s_axi_arvalid;  // Write wins

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      wreq         <= 1'b0;
      rreq         <= 1'b0;
      s_axi_bvalid <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      wreq <= wr_start;
      rreq <= rd_start;
      case (state)
        ST_IDLE: begin
          if (wr_start) state <= ST_WR_WAIT;
          else if (rd_start) state <= ST_RD_WAIT;
        end
        ST_WR_WAIT: begin
          if (wack) begin
            s_axi_bvalid <= 1'b1;
            state        <= ST_WR_RESP;
          end
        end
        ST_WR_RESP: begin
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            state        <= ST_IDLE;
          end
        end
        ST_RD_WAIT: begin
          if (rack) begin
            s_axi_rvalid <= 1'b1;
            state        <= ST_RD_RESP;
          end
        end
        default: begin  // ST_RD_RESP
          if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            state        <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (wr_start) begin
      waddr <= s_axi_awaddr[`JRX_AXI_ADDR_W-1:2];  // Byte to word address
      wdata <= s_axi_wdata;
    end
    if (rd_start) raddr <= s_axi_araddr[`JRX_AXI_ADDR_W-1:2];
    if (rack) s_axi_rdata <= rdata;
  end

  // Handshake cycle is the strobe cycle
  assign s_axi_awready = wreq;
  assign s_axi_wready  = wreq;
  assign s_axi_arready = rreq;
  assign s_axi_bresp   = 2'b00;
  assign s_axi_rresp   = 2'b00;

  assign up_bus = '{wreq: wreq, waddr: waddr, wdata: wdata, rreq: rreq, raddr: raddr};

  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  a_one_strobe: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    !(up_bus.wreq && up_bus.rreq));

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
jesd_rx_pkg.sv
up_axi_bridge.sv
jesd_up_common.sv
jesd_up_sysref.sv
jesd_up_rx.sv
axi_jesd_rx_regs.sv
tb_axi_jesd_rx.sv
